/* design/csr_pkg.sv */
// ============================
// CSR package
// Address map, reset values, field positions and shared types
// for the accelerator host register block
// ============================
package csr_pkg;

  // Bus widths
  localparam int CSR_ADDR_W = 8;
  localparam int CSR_DATA_W = 32;

  // ============================
  // Address map, byte offsets
  // ============================
  localparam logic [CSR_ADDR_W-1:0] ADDR_CTRL      = 8'h00;
  localparam logic [CSR_ADDR_W-1:0] ADDR_DIMS_M    = 8'h04;
  localparam logic [CSR_ADDR_W-1:0] ADDR_DIMS_N    = 8'h08;
  localparam logic [CSR_ADDR_W-1:0] ADDR_DIMS_K    = 8'h0C;
  localparam logic [CSR_ADDR_W-1:0] ADDR_TILES_TM  = 8'h10;
  localparam logic [CSR_ADDR_W-1:0] ADDR_TILES_TN  = 8'h14;
  localparam logic [CSR_ADDR_W-1:0] ADDR_TILES_TK  = 8'h18;
  localparam logic [CSR_ADDR_W-1:0] ADDR_INDEX_M   = 8'h1C;
  localparam logic [CSR_ADDR_W-1:0] ADDR_INDEX_N   = 8'h20;
  localparam logic [CSR_ADDR_W-1:0] ADDR_INDEX_K   = 8'h24;
  localparam logic [CSR_ADDR_W-1:0] ADDR_BUFF      = 8'h28;
  localparam logic [CSR_ADDR_W-1:0] ADDR_SCALE_SA  = 8'h2C;
  localparam logic [CSR_ADDR_W-1:0] ADDR_SCALE_SW  = 8'h30;
  localparam logic [CSR_ADDR_W-1:0] ADDR_STATUS    = 8'h3C;
  // Weight DMA channel
  localparam logic [CSR_ADDR_W-1:0] ADDR_DMA_SRC   = 8'h90;
  localparam logic [CSR_ADDR_W-1:0] ADDR_DMA_DST   = 8'h94;
  localparam logic [CSR_ADDR_W-1:0] ADDR_DMA_LEN   = 8'h98;
  localparam logic [CSR_ADDR_W-1:0] ADDR_DMA_CTRL  = 8'h9C;
  localparam logic [CSR_ADDR_W-1:0] ADDR_DMA_BYTES = 8'hB8;

  // Float32 encoding of 1.0
  localparam logic [CSR_DATA_W-1:0] SCALE_ONE     = 32'h3F80_0000;
  // Read value for holes in the map
  localparam logic [CSR_DATA_W-1:0] BAD_ADDR_DATA = 32'hDEAD_BEEF;

  // ============================
  // Field positions
  // ============================
  // CTRL: start and abort are write-one pulses, irq_en is RW
  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_ABORT_BIT  = 1;
  localparam int CTRL_IRQ_EN_BIT = 2;
  // STATUS: busy is RO, done and illegal are W1C
  localparam int ST_BUSY_BIT     = 0;
  localparam int ST_DONE_BIT     = 1;
  localparam int ST_ILLEGAL_BIT  = 9;
  // DMA control
  localparam int DMA_START_BIT   = 0;
  localparam int DMA_BUSY_BIT    = 1;
  localparam int DMA_DONE_BIT    = 2;
  // BUFF read-bank mirrors
  localparam int BUFF_RD_A_BIT   = 8;
  localparam int BUFF_RD_B_BIT   = 9;

  // Decoded register of a host access
  typedef enum logic [4:0] {
    REG_NONE,
    REG_CTRL,
    REG_DIMS_M,
    REG_DIMS_N,
    REG_DIMS_K,
    REG_TILES_TM,
    REG_TILES_TN,
    REG_TILES_TK,
    REG_INDEX_M,
    REG_INDEX_N,
    REG_INDEX_K,
    REG_BUFF,
    REG_SCALE_SA,
    REG_SCALE_SW,
    REG_STATUS,
    REG_DMA_SRC,
    REG_DMA_DST,
    REG_DMA_LEN,
    REG_DMA_CTRL,
    REG_DMA_BYTES
  } csr_reg_e;

  // Module that owns a register
  typedef enum logic [1:0] {
    GRP_NONE,
    GRP_JOB,
    GRP_STATUS,
    GRP_DMA
  } csr_group_e;

  // Job configuration as seen by the core
  typedef struct packed {
    logic [CSR_DATA_W-1:0] m;
    logic [CSR_DATA_W-1:0] n;
    logic [CSR_DATA_W-1:0] k;
    logic [CSR_DATA_W-1:0] tm;
    logic [CSR_DATA_W-1:0] tn;
    logic [CSR_DATA_W-1:0] tk;
    logic [CSR_DATA_W-1:0] m_idx;
    logic [CSR_DATA_W-1:0] n_idx;
    logic [CSR_DATA_W-1:0] k_idx;
    logic [CSR_DATA_W-1:0] sa;
    logic [CSR_DATA_W-1:0] sw;
    logic                  bank_wr_a;
    logic                  bank_wr_b;
  } job_cfg_t;

endpackage

/* design/csr_reg_if.sv */
// ============================
// Register group bus
// Decoder to group link: strobe, selector, data both ways
// ============================
`timescale 1ns/1ps

interface csr_reg_if import csr_pkg::*; ();

  // Write strobe, only for the owning group
  logic                  wr;
  // Decoded register, shared by reads and writes
  csr_reg_e              sel;
  logic [CSR_DATA_W-1:0] wdata;
  // Read data of the selected register, zero if not ours
  logic [CSR_DATA_W-1:0] rdata;

  modport decoder (
    output wr,
    output sel,
    output wdata,
    input  rdata
  );

  modport regs (
    input  wr,
    input  sel,
    input  wdata,
    output rdata
  );

endinterface

/* design/csr_decode.sv */
// ============================
// CSR address decoder
// Maps host addresses to registers, steers writes to the
// owning group and selects host read data
// ============================
`timescale 1ns/1ps

module csr_decode import csr_pkg::*; (
  input  logic                  wen,
  // Read data is valid whenever addressed, ren only qualifies the host side
  input  logic                  ren,
  input  logic [CSR_ADDR_W-1:0] addr,
  input  logic [CSR_DATA_W-1:0] wdata,
  output logic [CSR_DATA_W-1:0] rdata,
  csr_reg_if.decoder            job_bus,
  csr_reg_if.decoder            status_bus,
  csr_reg_if.decoder            dma_bus
);

  csr_reg_e   reg_sel;
  csr_group_e grp;

  // ============================
  // Address to register
  // ============================
  always_comb begin
    case (addr)
      ADDR_CTRL:      reg_sel = REG_CTRL;
      ADDR_DIMS_M:    reg_sel = REG_DIMS_M;
      ADDR_DIMS_N:    reg_sel = REG_DIMS_N;
      ADDR_DIMS_K:    reg_sel = REG_DIMS_K;
      ADDR_TILES_TM:  reg_sel = REG_TILES_TM;
      ADDR_TILES_TN:  reg_sel = REG_TILES_TN;
      ADDR_TILES_TK:  reg_sel = REG_TILES_TK;
      ADDR_INDEX_M:   reg_sel = REG_INDEX_M;
      ADDR_INDEX_N:   reg_sel = REG_INDEX_N;
      ADDR_INDEX_K:   reg_sel = REG_INDEX_K;
      ADDR_BUFF:      reg_sel = REG_BUFF;
      ADDR_SCALE_SA:  reg_sel = REG_SCALE_SA;
      ADDR_SCALE_SW:  reg_sel = REG_SCALE_SW;
      ADDR_STATUS:    reg_sel = REG_STATUS;
      ADDR_DMA_SRC:   reg_sel = REG_DMA_SRC;
      ADDR_DMA_DST:   reg_sel = REG_DMA_DST;
      ADDR_DMA_LEN:   reg_sel = REG_DMA_LEN;
      ADDR_DMA_CTRL:  reg_sel = REG_DMA_CTRL;
      ADDR_DMA_BYTES: reg_sel = REG_DMA_BYTES;
      // Holes and dropped blocks
      default:        reg_sel = REG_NONE;
    endcase
  end

  // Register to owning group
  always_comb begin
    case (reg_sel)
      REG_CTRL, REG_STATUS: grp = GRP_STATUS;
      REG_DIMS_M, REG_DIMS_N, REG_DIMS_K,
      REG_TILES_TM, REG_TILES_TN, REG_TILES_TK,
      REG_INDEX_M, REG_INDEX_N, REG_INDEX_K,
      REG_BUFF, REG_SCALE_SA, REG_SCALE_SW: grp = GRP_JOB;
      REG_DMA_SRC, REG_DMA_DST, REG_DMA_LEN,
      REG_DMA_CTRL, REG_DMA_BYTES: grp = GRP_DMA;
      default: grp = GRP_NONE;
    endcase
  end

  // ============================
  // Group buses
  // ============================
  // Selector and data fan out to all groups
  assign job_bus.sel      = reg_sel;
  assign job_bus.wdata    = wdata;
  assign status_bus.sel   = reg_sel;
  assign status_bus.wdata = wdata;
  assign dma_bus.sel      = reg_sel;
  assign dma_bus.wdata    = wdata;

  // Strobe only the owner
  assign job_bus.wr    = wen && (grp == GRP_JOB);
  assign status_bus.wr = wen && (grp == GRP_STATUS);
  assign dma_bus.wr    = wen && (grp == GRP_DMA);

  // Host read data from the owner, zero latency
  always_comb begin
    case (grp)
      GRP_JOB:    rdata = job_bus.rdata;
      GRP_STATUS: rdata = status_bus.rdata;
      GRP_DMA:    rdata = dma_bus.rdata;
      default:    rdata = BAD_ADDR_DATA;
    endcase
  end

endmodule

/* design/csr_job_regs.sv */
// ============================
// Job configuration registers
// Dimensions, tiles, indices, bank selects and scales
// ============================
`timescale 1ns/1ps

module csr_job_regs import csr_pkg::*; (
  input  logic      clk_gated,
  input  logic      rst_n,
  csr_reg_if.regs   bus,
  // Read bank mirrors from the core
  input  logic      bank_rd_a,
  input  logic      bank_rd_b,
  output job_cfg_t  cfg
);

  job_cfg_t cfg_q;

  // ============================
  // Register writes
  // ============================
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q    <= '0;
      // Unity scale until software sets one
      cfg_q.sa <= SCALE_ONE;
      cfg_q.sw <= SCALE_ONE;
    end else if (bus.wr) begin
      case (bus.sel)
        REG_DIMS_M:   cfg_q.m     <= bus.wdata;
        REG_DIMS_N:   cfg_q.n     <= bus.wdata;
        REG_DIMS_K:   cfg_q.k     <= bus.wdata;
        REG_TILES_TM: cfg_q.tm    <= bus.wdata;
        REG_TILES_TN: cfg_q.tn    <= bus.wdata;
        REG_TILES_TK: cfg_q.tk    <= bus.wdata;
        REG_INDEX_M:  cfg_q.m_idx <= bus.wdata;
        REG_INDEX_N:  cfg_q.n_idx <= bus.wdata;
        REG_INDEX_K:  cfg_q.k_idx <= bus.wdata;
        // Only the write-bank bits are writable
        REG_BUFF: begin
          cfg_q.bank_wr_a <= bus.wdata[0];
          cfg_q.bank_wr_b <= bus.wdata[1];
        end
        REG_SCALE_SA: cfg_q.sa    <= bus.wdata;
        REG_SCALE_SW: cfg_q.sw    <= bus.wdata;
        default: ;
      endcase
    end
  end

  // ============================
  // Readback
  // ============================
  always_comb begin
    bus.rdata = '0;
    case (bus.sel)
      REG_DIMS_M:   bus.rdata = cfg_q.m;
      REG_DIMS_N:   bus.rdata = cfg_q.n;
      REG_DIMS_K:   bus.rdata = cfg_q.k;
      REG_TILES_TM: bus.rdata = cfg_q.tm;
      REG_TILES_TN: bus.rdata = cfg_q.tn;
      REG_TILES_TK: bus.rdata = cfg_q.tk;
      REG_INDEX_M:  bus.rdata = cfg_q.m_idx;
      REG_INDEX_N:  bus.rdata = cfg_q.n_idx;
      REG_INDEX_K:  bus.rdata = cfg_q.k_idx;
      REG_BUFF: begin
        // Write banks low, live read banks above
        bus.rdata[0]             = cfg_q.bank_wr_a;
        bus.rdata[1]             = cfg_q.bank_wr_b;
        bus.rdata[BUFF_RD_A_BIT] = bank_rd_a;
        bus.rdata[BUFF_RD_B_BIT] = bank_rd_b;
      end
      REG_SCALE_SA: bus.rdata = cfg_q.sa;
      REG_SCALE_SW: bus.rdata = cfg_q.sw;
      default:      bus.rdata = '0;
    endcase
  end

  // Live configuration to the core
  assign cfg = cfg_q;

endmodule

/* design/csr_status.sv */
// ============================
// Control and status registers
// CTRL pulses with start guard, sticky STATUS bits
// ============================
`timescale 1ns/1ps

module csr_status import csr_pkg::*; (
  input  logic      clk_gated,
  input  logic      rst_n,
  csr_reg_if.regs   bus,
  input  job_cfg_t  cfg,
  input  logic      core_busy,
  input  logic      core_done_tile,
  input  logic      illegal_cmd,
  output logic      start_pulse,
  output logic      abort_pulse,
  output logic      irq_en
);

  logic ctrl_wr;
  logic status_wr;
  logic start_req;
  logic tiles_zero;
  logic start_blocked;
  logic st_done;
  logic st_illegal;

  // Write decode within the group
  assign ctrl_wr   = bus.wr && (bus.sel == REG_CTRL);
  assign status_wr = bus.wr && (bus.sel == REG_STATUS);

  // ============================
  // Start guard
  // ============================
  // Commands stay quiet while reset is held
  assign start_req     = rst_n && ctrl_wr && bus.wdata[CTRL_START_BIT];
  // Any zero tile size makes the job unrunnable
  assign tiles_zero    = (cfg.tm == '0) || (cfg.tn == '0) || (cfg.tk == '0);
  assign start_blocked = start_req && (core_busy || tiles_zero);
  assign start_pulse   = start_req && !core_busy && !tiles_zero;
  assign abort_pulse   = rst_n && ctrl_wr && bus.wdata[CTRL_ABORT_BIT];

  // irq_en and sticky bits
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      irq_en     <= 1'b0;
      st_done    <= 1'b0;
      st_illegal <= 1'b0;
    end else begin
      if (ctrl_wr)
        irq_en <= bus.wdata[CTRL_IRQ_EN_BIT];
      // Set beats a same-cycle W1C
      if (core_done_tile)
        st_done <= 1'b1;
      else if (status_wr && bus.wdata[ST_DONE_BIT])
        st_done <= 1'b0;
      if (illegal_cmd || start_blocked)
        st_illegal <= 1'b1;
      else if (status_wr && bus.wdata[ST_ILLEGAL_BIT])
        st_illegal <= 1'b0;
    end
  end

  // Readback with the pulse bits always at 0
  always_comb begin
    bus.rdata = '0;
    case (bus.sel)
      REG_CTRL:
        bus.rdata[CTRL_IRQ_EN_BIT] = irq_en;
      REG_STATUS: begin
        bus.rdata[ST_BUSY_BIT]    = core_busy;
        bus.rdata[ST_DONE_BIT]    = st_done;
        bus.rdata[ST_ILLEGAL_BIT] = st_illegal;
      end
      default: bus.rdata = '0;
    endcase
  end

endmodule

/* design/csr_dma_regs.sv */
// ============================
// Weight DMA channel registers
// Source, destination, length, start pulse and done flag
// ============================
`timescale 1ns/1ps

module csr_dma_regs import csr_pkg::*; (
  input  logic                  clk_gated,
  input  logic                  rst_n,
  csr_reg_if.regs               bus,
  input  logic                  dma_busy,
  input  logic                  dma_done,
  input  logic [CSR_DATA_W-1:0] dma_bytes,
  output logic [CSR_DATA_W-1:0] dma_src,
  output logic [CSR_DATA_W-1:0] dma_dst,
  output logic [CSR_DATA_W-1:0] dma_len,
  output logic                  dma_start_pulse
);

  logic ctrl_wr;
  logic st_dma_done;

  assign ctrl_wr         = bus.wr && (bus.sel == REG_DMA_CTRL);
  // Kick the channel in the write cycle once out of reset
  assign dma_start_pulse = rst_n && ctrl_wr && bus.wdata[DMA_START_BIT];

  // Address and length registers
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      dma_src <= '0;
      dma_dst <= '0;
      dma_len <= '0;
    end else if (bus.wr) begin
      case (bus.sel)
        REG_DMA_SRC: dma_src <= bus.wdata;
        REG_DMA_DST: dma_dst <= bus.wdata;
        REG_DMA_LEN: dma_len <= bus.wdata;
        default: ;
      endcase
    end
  end

  // Done flag where completion wins over a clear
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n)
      st_dma_done <= 1'b0;
    else if (dma_done)
      st_dma_done <= 1'b1;
    else if (ctrl_wr && bus.wdata[DMA_DONE_BIT])
      st_dma_done <= 1'b0;
  end

  // Readback
  always_comb begin
    bus.rdata = '0;
    case (bus.sel)
      REG_DMA_SRC:   bus.rdata = dma_src;
      REG_DMA_DST:   bus.rdata = dma_dst;
      REG_DMA_LEN:   bus.rdata = dma_len;
      REG_DMA_CTRL: begin
        bus.rdata[DMA_BUSY_BIT] = dma_busy;
        bus.rdata[DMA_DONE_BIT] = st_dma_done;
      end
      REG_DMA_BYTES: bus.rdata = dma_bytes;
      default:       bus.rdata = '0;
    endcase
  end

endmodule

/* design/accel_csr.sv */
// ============================
// Accelerator CSR top
// Host register block: decoder plus job, status and DMA groups
// ============================
`timescale 1ns/1ps

module accel_csr import csr_pkg::*; (
  input  logic                  clk_gated,
  input  logic                  rst_n,
  // Host bus
  input  logic                  wen,
  input  logic                  ren,
  input  logic [CSR_ADDR_W-1:0] addr,
  input  logic [CSR_DATA_W-1:0] wdata,
  output logic [CSR_DATA_W-1:0] rdata,
  // Core events
  input  logic                  core_busy,
  input  logic                  core_done_tile,
  input  logic                  illegal_cmd,
  input  logic                  bank_rd_a,
  input  logic                  bank_rd_b,
  // DMA status
  input  logic                  dma_busy,
  input  logic                  dma_done,
  input  logic [CSR_DATA_W-1:0] dma_bytes,
  // Core commands
  output logic                  start_pulse,
  output logic                  abort_pulse,
  output logic                  irq_en,
  // Job configuration
  output logic [CSR_DATA_W-1:0] dim_m,
  output logic [CSR_DATA_W-1:0] dim_n,
  output logic [CSR_DATA_W-1:0] dim_k,
  output logic [CSR_DATA_W-1:0] tile_m,
  output logic [CSR_DATA_W-1:0] tile_n,
  output logic [CSR_DATA_W-1:0] tile_k,
  output logic [CSR_DATA_W-1:0] idx_m,
  output logic [CSR_DATA_W-1:0] idx_n,
  output logic [CSR_DATA_W-1:0] idx_k,
  output logic                  bank_wr_a,
  output logic                  bank_wr_b,
  output logic [CSR_DATA_W-1:0] scale_a,
  output logic [CSR_DATA_W-1:0] scale_b,
  // Weight DMA channel
  output logic [CSR_DATA_W-1:0] dma_src,
  output logic [CSR_DATA_W-1:0] dma_dst,
  output logic [CSR_DATA_W-1:0] dma_len,
  output logic                  dma_start_pulse
);

  job_cfg_t cfg;

  // One bus per register group
  csr_reg_if job_bus ();
  csr_reg_if status_bus ();
  csr_reg_if dma_bus ();

  // ============================
  // Instances
  // ============================
  csr_decode csr_decode_inst (
    .wen        (wen),
    .ren        (ren),
    .addr       (addr),
    .wdata      (wdata),
    .rdata      (rdata),
    .job_bus    (job_bus),
    .status_bus (status_bus),
    .dma_bus    (dma_bus)
  );

  csr_job_regs csr_job_regs_inst (
    .clk_gated (clk_gated),
    .rst_n     (rst_n),
    .bus       (job_bus),
    .bank_rd_a (bank_rd_a),
    .bank_rd_b (bank_rd_b),
    .cfg       (cfg)
  );

  // Tile sizes feed the start guard
  csr_status csr_status_inst (
    .clk_gated      (clk_gated),
    .rst_n          (rst_n),
    .bus            (status_bus),
    .cfg            (cfg),
    .core_busy      (core_busy),
    .core_done_tile (core_done_tile),
    .illegal_cmd    (illegal_cmd),
    .start_pulse    (start_pulse),
    .abort_pulse    (abort_pulse),
    .irq_en         (irq_en)
  );

  csr_dma_regs csr_dma_regs_inst (
    .clk_gated       (clk_gated),
    .rst_n           (rst_n),
    .bus             (dma_bus),
    .dma_busy        (dma_busy),
    .dma_done        (dma_done),
    .dma_bytes       (dma_bytes),
    .dma_src         (dma_src),
    .dma_dst         (dma_dst),
    .dma_len         (dma_len),
    .dma_start_pulse (dma_start_pulse)
  );

  // Unpack job configuration onto plain ports
  assign dim_m     = cfg.m;
  assign dim_n     = cfg.n;
  assign dim_k     = cfg.k;
  assign tile_m    = cfg.tm;
  assign tile_n    = cfg.tn;
  assign tile_k    = cfg.tk;
  assign idx_m     = cfg.m_idx;
  assign idx_n     = cfg.n_idx;
  assign idx_k     = cfg.k_idx;
  assign bank_wr_a = cfg.bank_wr_a;
  assign bank_wr_b = cfg.bank_wr_b;
  assign scale_a   = cfg.sa;
  assign scale_b   = cfg.sw;

endmodule

/* verif/accel_csr_props.sv */
// ============================
// CSR command pulse properties
// Bound to the CSR top, checks start, abort and DMA pulses
// ============================
`timescale 1ns/1ps

module accel_csr_props (
  input logic clk_gated,
  input logic rst_n,
  input logic wen,
  input logic core_busy,
  input logic start_pulse,
  input logic abort_pulse,
  input logic dma_start_pulse
);

  // A start only goes out on a host write to an idle core
  start_on_idle_write: assert property (
    @(posedge clk_gated) disable iff (!rst_n) start_pulse |-> (wen && !core_busy)
  ) else $error("start_pulse without a host write to an idle core");

  abort_on_write: assert property (
    @(posedge clk_gated) disable iff (!rst_n) abort_pulse |-> wen
  ) else $error("abort_pulse without a host write");

  dma_start_on_write: assert property (
    @(posedge clk_gated) disable iff (!rst_n) dma_start_pulse |-> wen
  ) else $error("dma_start_pulse without a host write");

  // Quiet command lines while reset is held
  pulses_low_in_reset: assert property (
    @(posedge clk_gated) !rst_n |-> !(start_pulse || abort_pulse || dma_start_pulse)
  ) else $error("command pulse during reset");

endmodule

bind accel_csr accel_csr_props accel_csr_props_inst (
  .clk_gated       (clk_gated),
  .rst_n           (rst_n),
  .wen             (wen),
  .core_busy       (core_busy),
  .start_pulse     (start_pulse),
  .abort_pulse     (abort_pulse),
  .dma_start_pulse (dma_start_pulse)
);

/* verif/accel_csr_tb.sv */
// ============================
// Accelerator CSR testbench
// Random host traffic against a register model with checks
// ============================
`timescale 1ns/1ps

module accel_csr_tb import csr_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 4000;

  // DUT ports
  logic        clk_gated, rst_n, wen, ren;
  logic [7:0]  addr;
  logic [31:0] wdata, rdata;
  logic        core_busy, core_done_tile, illegal_cmd, bank_rd_a, bank_rd_b;
  logic        dma_busy, dma_done;
  logic [31:0] dma_bytes;
  logic        start_pulse, abort_pulse, irq_en, bank_wr_a, bank_wr_b;
  logic [31:0] dim_m, dim_n, dim_k, tile_m, tile_n, tile_k;
  logic [31:0] idx_m, idx_n, idx_k, scale_a, scale_b;
  logic [31:0] dma_src, dma_dst, dma_len;
  logic        dma_start_pulse;

  // Core side values for the next cycle
  logic        nx_busy, nx_done, nx_ill, nx_rd_a, nx_rd_b;
  logic        nx_dma_busy, nx_dma_done;
  logic [31:0] nx_dma_bytes;

  // Register model
  logic [31:0] shadow [0:255];
  logic        m_bank_wr_a, m_bank_wr_b, m_irq_en, m_done, m_illegal, m_dma_done;
  logic [7:0]  kept_addr [0:18] = '{ADDR_CTRL, ADDR_DIMS_M, ADDR_DIMS_N, ADDR_DIMS_K,
    ADDR_TILES_TM, ADDR_TILES_TN, ADDR_TILES_TK, ADDR_INDEX_M, ADDR_INDEX_N,
    ADDR_INDEX_K, ADDR_BUFF, ADDR_SCALE_SA, ADDR_SCALE_SW, ADDR_STATUS,
    ADDR_DMA_SRC, ADDR_DMA_DST, ADDR_DMA_LEN, ADDR_DMA_CTRL, ADDR_DMA_BYTES};

  integer seed = 19;
  int     errors = 0;
  int     checks = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     test_err_start = 0;
  int     cycle_count;

  accel_csr accel_csr_inst (.*);

  initial begin
    clk_gated = 1'b0;
    forever #2 clk_gated = ~clk_gated;
  end

  // Run limit at roughly twice the full test length
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_gated);
      cycle_count++;
    end
    $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // Plain read/write registers held in the shadow array
  function automatic logic is_plain_rw(input logic [7:0] a);
    case (a)
      ADDR_DIMS_M, ADDR_DIMS_N, ADDR_DIMS_K, ADDR_TILES_TM, ADDR_TILES_TN,
      ADDR_TILES_TK, ADDR_INDEX_M, ADDR_INDEX_N, ADDR_INDEX_K, ADDR_SCALE_SA,
      ADDR_SCALE_SW, ADDR_DMA_SRC, ADDR_DMA_DST, ADDR_DMA_LEN: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic in_map(input logic [7:0] a);
    return is_plain_rw(a) || (a == ADDR_CTRL) || (a == ADDR_BUFF) ||
           (a == ADDR_STATUS) || (a == ADDR_DMA_CTRL) || (a == ADDR_DMA_BYTES);
  endfunction

  // Expected host read data from model state and current core inputs
  function automatic logic [31:0] expected_read(input logic [7:0] a);
    logic [31:0] v;
    v = 32'h0;
    case (a)
      ADDR_CTRL:      v[CTRL_IRQ_EN_BIT] = m_irq_en;
      ADDR_STATUS: begin
        v[ST_BUSY_BIT]    = core_busy;
        v[ST_DONE_BIT]    = m_done;
        v[ST_ILLEGAL_BIT] = m_illegal;
      end
      ADDR_BUFF: begin
        v[0]             = m_bank_wr_a;
        v[1]             = m_bank_wr_b;
        v[BUFF_RD_A_BIT] = bank_rd_a;
        v[BUFF_RD_B_BIT] = bank_rd_b;
      end
      ADDR_DMA_CTRL: begin
        v[DMA_BUSY_BIT] = dma_busy;
        v[DMA_DONE_BIT] = m_dma_done;
      end
      ADDR_DMA_BYTES: v = dma_bytes;
      default:        v = is_plain_rw(a) ? shadow[a] : BAD_ADDR_DATA;
    endcase
    return v;
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (errors != test_err_start)
      tests_failed++;
    $display("%s: %0d errors", name, errors - test_err_start);
    test_err_start = errors;
  endtask

  // Drive one host cycle on the falling edge, check it mid cycle and advance the model
  task automatic bus_cycle(input logic w, input logic [7:0] a, input logic [31:0] d);
    logic [31:0] exp_rd;
    logic        tiles_ok;
    logic        start_req;
    logic        exp_start;
    logic        exp_abort;
    logic        exp_dma_start;
    @(negedge clk_gated);
    wen = w;
    ren = !w;
    addr = a;
    wdata = d;
    core_busy = nx_busy;
    core_done_tile = nx_done;
    illegal_cmd = nx_ill;
    bank_rd_a = nx_rd_a;
    bank_rd_b = nx_rd_b;
    dma_busy = nx_dma_busy;
    dma_done = nx_dma_done;
    dma_bytes = nx_dma_bytes;
    // Events last one cycle
    nx_done = 1'b0;
    nx_ill = 1'b0;
    nx_dma_done = 1'b0;
    #1;
    exp_rd = expected_read(a);
    tiles_ok = (shadow[ADDR_TILES_TM] != 0) && (shadow[ADDR_TILES_TN] != 0) &&
               (shadow[ADDR_TILES_TK] != 0);
    start_req = w && (a == ADDR_CTRL) && d[CTRL_START_BIT];
    exp_start = start_req && !core_busy && tiles_ok;
    exp_abort = w && (a == ADDR_CTRL) && d[CTRL_ABORT_BIT];
    exp_dma_start = w && (a == ADDR_DMA_CTRL) && d[DMA_START_BIT];
    checks += 5;
    if (rdata !== exp_rd)
      flag_error($sformatf("read of 0x%h gave %h, expected %h", a, rdata, exp_rd));
    if ({start_pulse, abort_pulse, dma_start_pulse} !== {exp_start, exp_abort, exp_dma_start})
      flag_error($sformatf("pulses start/abort/dma %b%b%b, expected %b%b%b", start_pulse,
        abort_pulse, dma_start_pulse, exp_start, exp_abort, exp_dma_start));
    if ({dim_m, dim_n, dim_k, tile_m, tile_n, tile_k} !== {shadow[ADDR_DIMS_M],
        shadow[ADDR_DIMS_N], shadow[ADDR_DIMS_K], shadow[ADDR_TILES_TM],
        shadow[ADDR_TILES_TN], shadow[ADDR_TILES_TK]})
      flag_error("dimension or tile outputs differ from the model");
    if ({idx_m, idx_n, idx_k, scale_a, scale_b, bank_wr_a, bank_wr_b, irq_en} !==
        {shadow[ADDR_INDEX_M], shadow[ADDR_INDEX_N], shadow[ADDR_INDEX_K],
        shadow[ADDR_SCALE_SA], shadow[ADDR_SCALE_SW], m_bank_wr_a, m_bank_wr_b, m_irq_en})
      flag_error("index, scale, bank or irq_en outputs differ from the model");
    if ({dma_src, dma_dst, dma_len} !==
        {shadow[ADDR_DMA_SRC], shadow[ADDR_DMA_DST], shadow[ADDR_DMA_LEN]})
      flag_error("DMA address or length outputs differ from the model");
    // A set wins over a same-cycle W1C on the sticky bits
    if (core_done_tile)
      m_done = 1'b1;
    else if (w && (a == ADDR_STATUS) && d[ST_DONE_BIT])
      m_done = 1'b0;
    if (illegal_cmd || (start_req && !exp_start))
      m_illegal = 1'b1;
    else if (w && (a == ADDR_STATUS) && d[ST_ILLEGAL_BIT])
      m_illegal = 1'b0;
    if (dma_done)
      m_dma_done = 1'b1;
    else if (w && (a == ADDR_DMA_CTRL) && d[DMA_DONE_BIT])
      m_dma_done = 1'b0;
    if (w && is_plain_rw(a))
      shadow[a] = d;
    if (w && (a == ADDR_CTRL))
      m_irq_en = d[CTRL_IRQ_EN_BIT];
    if (w && (a == ADDR_BUFF)) begin
      m_bank_wr_a = d[0];
      m_bank_wr_b = d[1];
    end
  endtask

  // Set an event with a read, clear it, then meet set and clear in one cycle
  task automatic sticky_check(input logic on_done);
    logic [31:0] bit_mask;
    bit_mask = on_done ? (32'h1 << ST_DONE_BIT) : (32'h1 << ST_ILLEGAL_BIT);
    nx_done = on_done;
    nx_ill = !on_done;
    bus_cycle(1'b0, ADDR_STATUS, 32'h0);
    bus_cycle(1'b1, ADDR_STATUS, bit_mask);
    bus_cycle(1'b0, ADDR_STATUS, 32'h0);
    nx_done = on_done;
    nx_ill = !on_done;
    bus_cycle(1'b1, ADDR_STATUS, bit_mask);
    bus_cycle(1'b0, ADDR_STATUS, 32'h0);
    if ((rdata & bit_mask) != bit_mask)
      flag_error("sticky bit lost when set and clear met");
  endtask

  initial begin
    logic [31:0] rnd;
    logic [7:0]  a;
    logic [4:0]  k;
    {wen, ren, addr, wdata, core_busy, core_done_tile, illegal_cmd} = '0;
    {bank_rd_a, bank_rd_b, dma_busy, dma_done, dma_bytes} = '0;
    {nx_busy, nx_done, nx_ill, nx_rd_a, nx_rd_b, nx_dma_busy, nx_dma_done} = '0;
    nx_dma_bytes = 32'h0;
    // Model reset state
    for (int j = 0; j < 256; j++)
      shadow[j] = 32'h0;
    shadow[ADDR_SCALE_SA] = SCALE_ONE;
    shadow[ADDR_SCALE_SW] = SCALE_ONE;
    {m_bank_wr_a, m_bank_wr_b, m_irq_en, m_done, m_illegal, m_dma_done} = '0;
    rst_n = 1'b0;
    // Command writes while reset is held must not leak out
    for (int r = 0; r < 15; r++) begin
      @(negedge clk_gated);
      wen = 1'b1;
      addr = r[0] ? ADDR_DMA_CTRL : ADDR_CTRL;
      wdata = 32'h7;
      #1;
      checks++;
      if ({start_pulse, abort_pulse, dma_start_pulse, irq_en} !== 4'b0000)
        flag_error("command pulse or irq_en while reset is held");
    end
    @(negedge clk_gated);
    wen = 1'b0;
    rst_n = 1'b1;

    // ============================
    // Reset values
    // ============================
    for (k = 5'd0; k < 5'd19; k = k + 5'd1)
      bus_cycle(1'b0, kept_addr[k], 32'h0);
    close_test("reset values");

    // Mixed random reads and writes with random core inputs
    repeat (1500) begin
      rnd = $random(seed);
      nx_busy = rnd[0] & rnd[1];
      nx_rd_a = rnd[2];
      nx_rd_b = rnd[3];
      nx_dma_busy = rnd[4];
      nx_done = (rnd[7:5] == 3'd0);
      nx_ill = (rnd[10:8] == 3'd0);
      nx_dma_done = (rnd[13:11] == 3'd0);
      nx_dma_bytes = $random(seed);
      a = (rnd[20:16] < 5'd19) ? kept_addr[rnd[20:16]] : rnd[31:24];
      bus_cycle(rnd[21], a, $random(seed));
    end
    nx_busy = 1'b0;
    close_test("random writes");

    // ============================
    // Start guard and abort
    // ============================
    bus_cycle(1'b1, ADDR_STATUS, 32'h0000_0202);
    bus_cycle(1'b1, ADDR_TILES_TM, 32'd4);
    bus_cycle(1'b1, ADDR_TILES_TN, 32'd8);
    bus_cycle(1'b1, ADDR_TILES_TK, 32'd2);
    bus_cycle(1'b1, ADDR_CTRL, 32'h1);
    if (start_pulse !== 1'b1)
      flag_error("no start_pulse for an allowed start");
    bus_cycle(1'b0, ADDR_STATUS, 32'h0);
    nx_busy = 1'b1;
    bus_cycle(1'b1, ADDR_CTRL, 32'h5);
    bus_cycle(1'b0, ADDR_STATUS, 32'h0);
    if (rdata[ST_ILLEGAL_BIT] !== 1'b1)
      flag_error("start while busy did not set the illegal bit");
    nx_busy = 1'b0;
    bus_cycle(1'b1, ADDR_STATUS, 32'h0000_0200);
    bus_cycle(1'b1, ADDR_TILES_TK, 32'h0);
    bus_cycle(1'b1, ADDR_CTRL, 32'h1);
    bus_cycle(1'b0, ADDR_STATUS, 32'h0);
    if (rdata[ST_ILLEGAL_BIT] !== 1'b1)
      flag_error("start with a zero tile did not set the illegal bit");
    bus_cycle(1'b1, ADDR_CTRL, 32'h2);
    if (abort_pulse !== 1'b1)
      flag_error("no abort_pulse for an abort write");
    close_test("start guard");

    // Sticky done and illegal bits, busy mirror
    sticky_check(1'b1);
    sticky_check(1'b0);
    nx_busy = 1'b1;
    bus_cycle(1'b0, ADDR_STATUS, 32'h0);
    nx_busy = 1'b0;
    bus_cycle(1'b0, ADDR_STATUS, 32'h0);
    close_test("sticky bits");

    // ============================
    // Weight DMA channel
    // ============================
    bus_cycle(1'b1, ADDR_DMA_SRC, $random(seed));
    bus_cycle(1'b1, ADDR_DMA_DST, $random(seed));
    bus_cycle(1'b1, ADDR_DMA_LEN, $random(seed));
    bus_cycle(1'b1, ADDR_DMA_CTRL, 32'h1);
    if (dma_start_pulse !== 1'b1)
      flag_error("no dma_start_pulse for a DMA start write");
    nx_dma_busy = 1'b1;
    nx_dma_done = 1'b1;
    bus_cycle(1'b0, ADDR_DMA_CTRL, 32'h0);
    nx_dma_busy = 1'b0;
    bus_cycle(1'b0, ADDR_DMA_CTRL, 32'h0);
    bus_cycle(1'b1, ADDR_DMA_CTRL, 32'h4);
    bus_cycle(1'b0, ADDR_DMA_CTRL, 32'h0);
    nx_dma_bytes = $random(seed);
    bus_cycle(1'b0, ADDR_DMA_BYTES, 32'h0);
    // Dropped activation DMA, BSR and counter offsets, then random holes
    bus_cycle(1'b0, 8'h40, 32'h0);
    bus_cycle(1'b0, 8'h60, 32'h0);
    bus_cycle(1'b1, 8'hA0, $random(seed));
    bus_cycle(1'b0, 8'hA0, 32'h0);
    bus_cycle(1'b0, 8'hC0, 32'h0);
    repeat (150) begin
      rnd = $random(seed);
      a = rnd[7:0];
      while (in_map(a))
        a = a + 8'd1;
      bus_cycle(rnd[8], a, $random(seed));
    end
    close_test("dma and unmapped");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* accel_csr.f */
design/csr_pkg.sv
design/csr_reg_if.sv
design/csr_decode.sv
design/csr_job_regs.sv
design/csr_status.sv
design/csr_dma_regs.sv
design/accel_csr.sv
verif/accel_csr_props.sv
verif/accel_csr_tb.sv

/* Makefile */
# Verilator flow for the accelerator CSR block

SIM := obj_dir/Vaccel_csr_tb

.PHONY: all run lint clean

all: run

$(SIM): accel_csr.f design/*.sv verif/*.sv
	verilator --binary --timing --assert --top-module accel_csr_tb -f accel_csr.f -o Vaccel_csr_tb

# Pass only when the log holds the pass line
run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module accel_csr_tb -f accel_csr.f

clean:
	rm -rf obj_dir sim.log
